// ==== Makefile ====
# Verilator build and run of the memory arbiter testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run the testbench, check the log"
	@echo "  make clean  remove the build directory and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f all.f --top-module memArbTb -Mdir obj_dir
	./obj_dir/VmemArbTb | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
hdl/memArbPkg.sv
hdl/reqDecode.sv
hdl/sigAddrGen.sv
hdl/xferEngine.sv
hdl/respRouter.sv
hdl/memArb.sv
bench/memModel.sv
bench/memArbTb.sv

// ==== bench/memArbTb.sv ====
`timescale 1ns/1ps

module memArbTb;
    import memArbPkg::*;

    localparam int NUM_ROUNDS = 6;
    localparam int NUM_TXN = NUM_ROUNDS * 6 + 5;     // six per round, five in the tail
    localparam int SIG_BLKS = 1 << SIG_OFF_W;
    localparam int CYCLE_LIMIT = NUM_TXN * SIG_BLKS * 16;
    localparam logic [ADDR_W-1:0] CACHE_MASK = 32'h0FFF_FFFF;  // stays below signal memory

    logic clk;
    logic rst;
    logic instrCacheBlkReq, dataCacheBlkReq, dataCacheEvictReq;
    logic accelDataRd, accelDataWr;
    logic instrBlk2CacheValid, dataBlk2CacheValid, dataEvictAck;
    logic accelRdBlkDone, accelWrBlkDone, transformComplete;
    logic tblWe, txDone, rdValid;
    logic [ADDR_W-1:0] instrAddr, dataAddr, ioAddr;
    logic [BLK_W-1:0] dataBlk2Mem, accelBlk2Mem, busOut, busIn;
    logic [BLK_W-1:0] instrBlk2Cache, dataBlk2Cache, accelBlk2Buffer;
    logic [SIG_NUM_W-1:0] sigNum, tblIdx;
    logic [SIG_BASE_W-1:0] tblBase;
    logic [OP_W-1:0] op;

    logic [BLK_W-1:0] refStore [logic [ADDR_W-1:0]];  // expected memory contents
    logic [SIG_BASE_W-1:0] refTbl [1 << SIG_NUM_W];   // copy of the signal table
    logic [OP_W-1:0] seenOp [$];                      // bus commands as accepted
    logic [ADDR_W-1:0] seenAddr [$];
    logic [BLK_W-1:0] seenData [$];
    logic [GNT_W-1:0] doneOrder [$];                  // requesters by final strobe
    int cycles = 0;

    memArb memArb_inst (.*);
    memModel memModel_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // same rule as the memory model for blocks never written
    function automatic logic [BLK_W-1:0] fillBlk(logic [ADDR_W-1:0] addr);
        logic [BLK_W-1:0] blk;
        for (int w = 0; w < BLK_W / 32; w++) begin
            blk[w*32 +: 32] = addr ^ (32'h9E37_79B9 * (w + 1)) ^ {addr[15:0], addr[31:16]};
        end
        return blk;
    endfunction

    function automatic logic [BLK_W-1:0] expBlk(logic [ADDR_W-1:0] addr);
        return refStore.exists(addr) ? refStore[addr] : fillBlk(addr);
    endfunction

    function automatic logic [ADDR_W-1:0] lineOf(logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:LINE_SHIFT], LINE_SHIFT'(0)};  // 64-byte line
    endfunction

    // block i of a signal, 2 KiB apart from the table base
    function automatic logic [ADDR_W-1:0] sigBlkAddr(logic [SIG_NUM_W-1:0] sig, int i);
        return SIG_REGION + ((ADDR_W'(refTbl[sig]) + ADDR_W'(i)) << SIG_STRIDE_SHIFT);
    endfunction

    function automatic logic [BLK_W-1:0] randBlk();
        logic [BLK_W-1:0] blk;
        for (int w = 0; w < BLK_W / 32; w++) begin
            blk[w*32 +: 32] = $urandom();
        end
        return blk;
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkBlk(string what, logic [BLK_W-1:0] got, logic [BLK_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkAddr(string what, logic [ADDR_W-1:0] got, logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkOp(string what, logic [OP_W-1:0] got, logic [OP_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic checkGrant(string what, logic [GNT_W-1:0] got, logic [GNT_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic checkStrobe(string what, logic got, logic exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // every command the memory accepted, in bus order
    always @(posedge clk) begin
        if (!rst && txDone && op != OP_IDLE) begin
            seenOp.push_back(op);
            seenAddr.push_back(ioAddr);
            seenData.push_back(busOut);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abortRun("timeout: the arbiter stopped making progress, run hung");
        end
    end

    task automatic matchBusRecord(string what, logic [OP_W-1:0] expOp,
                                  logic [ADDR_W-1:0] expAddr, logic [BLK_W-1:0] expData);
        logic [BLK_W-1:0] data;
        if (seenOp.size() == 0) begin
            abortRun({what, ": no memory transfer was seen on the bus"});
        end else begin
            data = seenData.pop_front();
            checkOp({what, " op"}, seenOp.pop_front(), expOp);
            checkAddr({what, " address"}, seenAddr.pop_front(), expAddr);
            if (expOp == OP_WRITE) begin
                checkBlk({what, " write data"}, data, expData);
            end
        end
    endtask

    // all requester tasks start and end on a falling edge
    task automatic instrFill(logic [ADDR_W-1:0] addr);
        instrAddr = addr;
        instrCacheBlkReq = 1'b1;
        @(negedge clk);
        while (!instrBlk2CacheValid) @(negedge clk);
        instrCacheBlkReq = 1'b0;  // drop before the next arbitration
        doneOrder.push_back(GNT_INSTR);
        checkBlk("instr fill block", instrBlk2Cache, expBlk(lineOf(addr)));
        matchBusRecord("instr fill", OP_READ, lineOf(addr), '0);
    endtask

    task automatic evict(logic [ADDR_W-1:0] addr, logic [BLK_W-1:0] blk);
        dataAddr = addr;
        dataBlk2Mem = blk;
        dataCacheEvictReq = 1'b1;
        @(negedge clk);
        while (!dataEvictAck) @(negedge clk);
        dataCacheEvictReq = 1'b0;
        doneOrder.push_back(GNT_DATA_WR);
        refStore[lineOf(addr)] = blk;
        matchBusRecord("eviction", OP_WRITE, lineOf(addr), blk);
    endtask

    task automatic dataFill(logic [ADDR_W-1:0] addr);
        dataAddr = addr;
        dataCacheBlkReq = 1'b1;
        @(negedge clk);
        while (!dataBlk2CacheValid) @(negedge clk);
        dataCacheBlkReq = 1'b0;
        doneOrder.push_back(GNT_DATA_RD);
        checkBlk("data fill block", dataBlk2Cache, expBlk(lineOf(addr)));
        matchBusRecord("data fill", OP_READ, lineOf(addr), '0);
    endtask

    task automatic accelRead(logic [SIG_NUM_W-1:0] sig);
        sigNum = sig;
        accelDataRd = 1'b1;
        for (int i = 0; i < SIG_BLKS; i++) begin
            @(negedge clk);
            while (!accelRdBlkDone) @(negedge clk);
            checkBlk($sformatf("accel read block %0d", i), accelBlk2Buffer,
                     expBlk(sigBlkAddr(sig, i)));
            checkStrobe("transformComplete on read", transformComplete, i == SIG_BLKS - 1);
        end
        accelDataRd = 1'b0;
        doneOrder.push_back(GNT_ACCEL_RD);
        for (int i = 0; i < SIG_BLKS; i++) begin
            matchBusRecord($sformatf("accel read %0d", i), OP_READ, sigBlkAddr(sig, i), '0);
        end
    endtask

    task automatic accelWrite(logic [SIG_NUM_W-1:0] sig);
        logic [BLK_W-1:0] blks [SIG_BLKS];
        for (int i = 0; i < SIG_BLKS; i++) begin
            blks[i] = randBlk();
        end
        sigNum = sig;
        accelBlk2Mem = blks[0];
        accelDataWr = 1'b1;
        for (int i = 0; i < SIG_BLKS; i++) begin
            @(negedge clk);
            while (!accelWrBlkDone) @(negedge clk);
            checkStrobe("transformComplete on write", transformComplete, i == SIG_BLKS - 1);
            refStore[sigBlkAddr(sig, i)] = blks[i];
            if (i < SIG_BLKS - 1) begin
                accelBlk2Mem = blks[i + 1];  // buffer moves on after each done
            end
        end
        accelDataWr = 1'b0;
        doneOrder.push_back(GNT_ACCEL_WR);
        for (int i = 0; i < SIG_BLKS; i++) begin
            matchBusRecord($sformatf("accel write %0d", i), OP_WRITE, sigBlkAddr(sig, i),
                           blks[i]);
        end
    endtask

    task automatic programTable(logic [SIG_NUM_W-1:0] idx, logic [SIG_BASE_W-1:0] base);
        tblWe = 1'b1;
        tblIdx = idx;
        tblBase = base;
        @(negedge clk);
        tblWe = 1'b0;
        refTbl[idx] = base;
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [SIG_NUM_W-1:0] sig;
        void'($urandom(86872));
        rst = 1'b1;
        instrCacheBlkReq = 1'b0;
        dataCacheBlkReq = 1'b0;
        dataCacheEvictReq = 1'b0;
        accelDataRd = 1'b0;
        accelDataWr = 1'b0;
        instrAddr = '0;
        dataAddr = '0;
        dataBlk2Mem = '0;
        accelBlk2Mem = '0;
        sigNum = '0;
        tblWe = 1'b0;
        tblIdx = '0;
        tblBase = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < (1 << SIG_NUM_W); i++) begin
            programTable(SIG_NUM_W'(i), SIG_BASE_W'($urandom()));
        end

        // mixed traffic, one requester at a time
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            instrFill($urandom() & CACHE_MASK);
            addr = $urandom() & CACHE_MASK;
            evict(addr, randBlk());
            dataFill(addr);  // returns the evicted block
            accelRead(SIG_NUM_W'($urandom()));
            sig = SIG_NUM_W'($urandom());
            accelWrite(sig);
            accelRead(sig);  // reads back what the memory stored
        end

        // every requester at once
        doneOrder.delete();
        addr = $urandom() & CACHE_MASK;
        sig = SIG_NUM_W'($urandom());
        fork
            accelRead(sig);
            evict(addr, randBlk());
            dataFill(addr);
            instrFill($urandom() & CACHE_MASK);
        join
        checkGrant("first completion", doneOrder[0], GNT_ACCEL_RD);
        checkGrant("second completion", doneOrder[1], GNT_DATA_WR);
        checkGrant("third completion", doneOrder[2], GNT_DATA_RD);
        checkGrant("fourth completion", doneOrder[3], GNT_INSTR);

        // new base must show in the next transfer of that signal
        sig = SIG_NUM_W'($urandom());
        programTable(sig, refTbl[sig] ^ SIG_BASE_W'($urandom() | 1));
        accelRead(sig);

        checkStrobe("all bus commands accounted for", seenOp.size() == 0, 1'b1);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== bench/memModel.sv ====
`timescale 1ns/1ps

module memModel (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [memArbPkg::OP_W-1:0]   op,
    input  logic [memArbPkg::ADDR_W-1:0] ioAddr,
    input  logic [memArbPkg::BLK_W-1:0]  busOut,
    output logic [memArbPkg::BLK_W-1:0]  busIn,
    output logic                         txDone,
    output logic                         rdValid
);
    import memArbPkg::*;

    logic [BLK_W-1:0] store [logic [ADDR_W-1:0]];  // written blocks only
    logic [1:0] phase;           // 0 idle, 1 command, 2 read data
    logic [ADDR_W-1:0] curAddr;  // address of the command in flight
    logic curRead;
    int waitCnt;                 // falling edges left in this phase

    // never-written blocks, pattern built from the whole address
    function automatic logic [BLK_W-1:0] fillBlk(logic [ADDR_W-1:0] addr);
        logic [BLK_W-1:0] blk;
        for (int w = 0; w < BLK_W / 32; w++) begin
            blk[w*32 +: 32] = addr ^ (32'h9E37_79B9 * (w + 1)) ^ {addr[15:0], addr[31:16]};
        end
        return blk;
    endfunction

    // outputs move on the falling edge, arbiter samples on the rising one
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            phase <= 2'd0;
            curAddr <= '0;
            curRead <= 1'b0;
            waitCnt <= 0;
            txDone <= 1'b0;
            rdValid <= 1'b0;
            busIn <= '0;
        end else begin
            txDone <= 1'b0;   // both strobes last one cycle
            rdValid <= 1'b0;
            case (phase)
                2'd0: begin
                    if (op != OP_IDLE) begin
                        curAddr <= ioAddr;
                        curRead <= (op == OP_READ);
                        waitCnt <= $urandom_range(1, 6);  // command latency
                        phase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (waitCnt > 1) begin
                        waitCnt <= waitCnt - 1;
                    end else begin
                        txDone <= 1'b1;
                        if (curRead) begin
                            waitCnt <= $urandom_range(1, 6);  // data latency
                            phase <= 2'd2;
                        end else begin
                            store[curAddr] = busOut;  // still held until txDone
                            phase <= 2'd0;
                        end
                    end
                end
                default: begin
                    if (waitCnt > 1) begin
                        waitCnt <= waitCnt - 1;
                    end else begin
                        rdValid <= 1'b1;
                        busIn <= store.exists(curAddr) ? store[curAddr] : fillBlk(curAddr);
                        phase <= 2'd0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/memArb.sv ====
`timescale 1ns/1ps

module memArb (
    input  logic                             clk,
    input  logic                             rst,
    // instruction cache
    input  logic                             instrCacheBlkReq,
    input  logic [memArbPkg::ADDR_W-1:0]     instrAddr,
    output logic [memArbPkg::BLK_W-1:0]      instrBlk2Cache,
    output logic                             instrBlk2CacheValid,
    // data cache
    input  logic                             dataCacheBlkReq,
    input  logic                             dataCacheEvictReq,
    input  logic [memArbPkg::ADDR_W-1:0]     dataAddr,
    input  logic [memArbPkg::BLK_W-1:0]      dataBlk2Mem,
    output logic [memArbPkg::BLK_W-1:0]      dataBlk2Cache,
    output logic                             dataBlk2CacheValid,
    output logic                             dataEvictAck,
    // accelerator buffer
    input  logic                             accelDataRd,
    input  logic                             accelDataWr,
    input  logic [memArbPkg::SIG_NUM_W-1:0]  sigNum,
    input  logic [memArbPkg::BLK_W-1:0]      accelBlk2Mem,
    output logic [memArbPkg::BLK_W-1:0]      accelBlk2Buffer,
    output logic                             accelRdBlkDone,
    output logic                             accelWrBlkDone,
    output logic                             transformComplete,
    // signal table port
    input  logic                             tblWe,
    input  logic [memArbPkg::SIG_NUM_W-1:0]  tblIdx,
    input  logic [memArbPkg::SIG_BASE_W-1:0] tblBase,
    // memory controller
    output logic [memArbPkg::OP_W-1:0]       op,
    output logic [memArbPkg::ADDR_W-1:0]     ioAddr,
    output logic [memArbPkg::BLK_W-1:0]      busOut,
    input  logic [memArbPkg::BLK_W-1:0]      busIn,
    input  logic                             txDone,
    input  logic                             rdValid
);
    import memArbPkg::*;

    logic [GNT_W-1:0] grant;      // current transfer owner
    logic [ADDR_W-1:0] sigAddr;
    logic lastBlk;
    logic rdStrobe;
    logic wrDone;
    logic blkAdvance;
    logic xferDone;

    reqDecode reqDecode_inst (
        .clk(clk),
        .rst(rst),
        .instrCacheBlkReq(instrCacheBlkReq),
        .dataCacheBlkReq(dataCacheBlkReq),
        .dataCacheEvictReq(dataCacheEvictReq),
        .accelDataRd(accelDataRd),
        .accelDataWr(accelDataWr),
        .xferDone(xferDone),
        .grant(grant)
    );

    sigAddrGen sigAddrGen_inst (
        .clk(clk),
        .rst(rst),
        .tblWe(tblWe),
        .tblIdx(tblIdx),
        .tblBase(tblBase),
        .sigNum(sigNum),
        .blkAdvance(blkAdvance),
        .sigAddr(sigAddr),
        .lastBlk(lastBlk)
    );

    xferEngine xferEngine_inst (
        .clk(clk),
        .rst(rst),
        .grant(grant),
        .instrAddr(instrAddr),
        .dataAddr(dataAddr),
        .sigAddr(sigAddr),
        .dataBlk2Mem(dataBlk2Mem),
        .accelBlk2Mem(accelBlk2Mem),
        .lastBlk(lastBlk),
        .txDone(txDone),
        .rdValid(rdValid),
        .op(op),
        .ioAddr(ioAddr),
        .busOut(busOut),
        .rdStrobe(rdStrobe),
        .wrDone(wrDone),
        .blkAdvance(blkAdvance),
        .xferDone(xferDone)
    );

    respRouter respRouter_inst (
        .clk(clk),
        .rst(rst),
        .grant(grant),
        .rdStrobe(rdStrobe),
        .wrDone(wrDone),
        .xferDone(xferDone),
        .busIn(busIn),
        .instrBlk2Cache(instrBlk2Cache),
        .dataBlk2Cache(dataBlk2Cache),
        .accelBlk2Buffer(accelBlk2Buffer),
        .instrBlk2CacheValid(instrBlk2CacheValid),
        .dataBlk2CacheValid(dataBlk2CacheValid),
        .dataEvictAck(dataEvictAck),
        .accelRdBlkDone(accelRdBlkDone),
        .accelWrBlkDone(accelWrBlkDone),
        .transformComplete(transformComplete)
    );

endmodule

// ==== hdl/memArbPkg.sv ====
package memArbPkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int BLK_W = 512;
    localparam int LINE_SHIFT = 6;   // 64-byte cache line

    // memory controller op codes
    localparam int OP_W = 2;
    localparam logic [OP_W-1:0] OP_IDLE = 2'd0;
    localparam logic [OP_W-1:0] OP_READ = 2'd1;
    localparam logic [OP_W-1:0] OP_WRITE = 2'd3;

    // grant codes, one per kind of transfer
    localparam int GNT_W = 3;
    localparam logic [GNT_W-1:0] GNT_NONE = 3'd0;
    localparam logic [GNT_W-1:0] GNT_INSTR = 3'd1;
    localparam logic [GNT_W-1:0] GNT_DATA_RD = 3'd2;
    localparam logic [GNT_W-1:0] GNT_DATA_WR = 3'd3;      // eviction
    localparam logic [GNT_W-1:0] GNT_ACCEL_RD = 3'd4;
    localparam logic [GNT_W-1:0] GNT_ACCEL_WR = 3'd5;

    // signal memory layout
    localparam int SIG_NUM_W = 4;    // sixteen table entries
    localparam int SIG_BASE_W = 18;  // base block number
    localparam int SIG_OFF_W = 3;    // eight blocks per signal
    localparam logic [ADDR_W-1:0] SIG_REGION = 32'h1000_0000;
    localparam int SIG_STRIDE_SHIFT = 11;  // 2 KiB between signal blocks

    // transfer engine states
    localparam int ENG_ST_W = 2;
    localparam logic [ENG_ST_W-1:0] ENG_IDLE = 2'd0;
    localparam logic [ENG_ST_W-1:0] ENG_ISSUE = 2'd1;
    localparam logic [ENG_ST_W-1:0] ENG_RD_WAIT = 2'd2;
    localparam logic [ENG_ST_W-1:0] ENG_WR_DONE = 2'd3;

endpackage

// ==== hdl/reqDecode.sv ====
`timescale 1ns/1ps

module reqDecode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instrCacheBlkReq,
    input  logic                        dataCacheBlkReq,
    input  logic                        dataCacheEvictReq,
    input  logic                        accelDataRd,
    input  logic                        accelDataWr,
    input  logic                        xferDone,
    output logic [memArbPkg::GNT_W-1:0] grant
);
    import memArbPkg::*;

    logic [GNT_W-1:0] winner;  // combinational pick
    logic anyReq;

    assign anyReq = instrCacheBlkReq | dataCacheBlkReq | dataCacheEvictReq
                  | accelDataRd | accelDataWr;

    // accel beats data beats instr
    always_comb begin
        winner = GNT_NONE;
        if (accelDataRd) begin
            winner = GNT_ACCEL_RD;  // read beats write
        end else if (accelDataWr) begin
            winner = GNT_ACCEL_WR;
        end else if (dataCacheEvictReq) begin
            winner = GNT_DATA_WR;   // evict beats fill
        end else if (dataCacheBlkReq) begin
            winner = GNT_DATA_RD;
        end else if (instrCacheBlkReq) begin
            winner = GNT_INSTR;
        end
    end

    // grant loads only from none and drops back to none after xferDone
    // the idle cycle lets the finished requester lower its request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= GNT_NONE;
        end else if (grant == GNT_NONE) begin
            if (anyReq) begin
                grant <= winner;
            end
        end else if (xferDone) begin
            grant <= GNT_NONE;
        end
    end

    // no switch between requesters in the middle of a transfer
    grantHeld: assert property (@(posedge clk) disable iff (rst)
        grant != $past(grant) |-> $past(grant) == GNT_NONE || $past(xferDone))
        else $error("grant changed during a transfer");

endmodule

// ==== hdl/respRouter.sv ====
`timescale 1ns/1ps

module respRouter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [memArbPkg::GNT_W-1:0] grant,
    input  logic                        rdStrobe,
    input  logic                        wrDone,
    input  logic                        xferDone,
    input  logic [memArbPkg::BLK_W-1:0] busIn,
    output logic [memArbPkg::BLK_W-1:0] instrBlk2Cache,
    output logic [memArbPkg::BLK_W-1:0] dataBlk2Cache,
    output logic [memArbPkg::BLK_W-1:0] accelBlk2Buffer,
    output logic                        instrBlk2CacheValid,
    output logic                        dataBlk2CacheValid,
    output logic                        dataEvictAck,
    output logic                        accelRdBlkDone,
    output logic                        accelWrBlkDone,
    output logic                        transformComplete
);
    import memArbPkg::*;

    logic rdInstr;
    logic rdData;
    logic rdAccel;
    logic isAccel;

    // which requester owns this read block
    assign rdInstr = rdStrobe && (grant == GNT_INSTR);
    assign rdData = rdStrobe && (grant == GNT_DATA_RD);
    assign rdAccel = rdStrobe && (grant == GNT_ACCEL_RD);
    assign isAccel = (grant == GNT_ACCEL_RD) || (grant == GNT_ACCEL_WR);

    // block registers keep the last fill
    always_ff @(posedge clk) begin
        if (rdInstr) begin
            instrBlk2Cache <= busIn;
        end
        if (rdData) begin
            dataBlk2Cache <= busIn;
        end
        if (rdAccel) begin
            accelBlk2Buffer <= busIn;
        end
    end

    // strobes, one cycle behind the engine event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instrBlk2CacheValid <= 1'b0;
            dataBlk2CacheValid <= 1'b0;
            dataEvictAck <= 1'b0;
            accelRdBlkDone <= 1'b0;
            accelWrBlkDone <= 1'b0;
            transformComplete <= 1'b0;
        end else begin
            instrBlk2CacheValid <= rdInstr;
            dataBlk2CacheValid <= rdData;
            dataEvictAck <= wrDone && (grant == GNT_DATA_WR);
            accelRdBlkDone <= rdAccel;
            accelWrBlkDone <= wrDone && (grant == GNT_ACCEL_WR);
            transformComplete <= xferDone && isAccel;  // with the eighth block
        end
    end

    oneStrobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({instrBlk2CacheValid, dataBlk2CacheValid, dataEvictAck,
                  accelRdBlkDone, accelWrBlkDone}))
        else $error("more than one requester strobe");

endmodule

// ==== hdl/sigAddrGen.sv ====
`timescale 1ns/1ps

module sigAddrGen (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             tblWe,
    input  logic [memArbPkg::SIG_NUM_W-1:0]  tblIdx,
    input  logic [memArbPkg::SIG_BASE_W-1:0] tblBase,
    input  logic [memArbPkg::SIG_NUM_W-1:0]  sigNum,
    input  logic                             blkAdvance,
    output logic [memArbPkg::ADDR_W-1:0]     sigAddr,
    output logic                             lastBlk
);
    import memArbPkg::*;

    localparam int TBL_DEPTH = 2 ** SIG_NUM_W;

    logic [SIG_BASE_W-1:0] baseTbl [TBL_DEPTH];  // base block per signal
    logic [SIG_OFF_W-1:0] blkOff;                // block within the signal
    logic [ADDR_W-1:0] blkNum;

    // signal table, written by the host port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < TBL_DEPTH; i++) begin
                baseTbl[i] <= '0;
            end
        end else if (tblWe) begin
            baseTbl[tblIdx] <= tblBase;  // visible from next edge
        end
    end

    // block offset, wraps to zero after the last block
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blkOff <= '0;
        end else if (blkAdvance) begin
            blkOff <= blkOff + 1'b1;
        end
    end

    // block number of the current signal block
    assign blkNum = ADDR_W'(baseTbl[sigNum]) + ADDR_W'(blkOff);

    // byte address inside the signal region
    assign sigAddr = SIG_REGION + (blkNum << SIG_STRIDE_SHIFT);

    assign lastBlk = &blkOff;  // offset 7

endmodule

// ==== hdl/xferEngine.sv ====
`timescale 1ns/1ps

module xferEngine (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [memArbPkg::GNT_W-1:0] grant,
    input  logic [memArbPkg::ADDR_W-1:0] instrAddr,
    input  logic [memArbPkg::ADDR_W-1:0] dataAddr,
    input  logic [memArbPkg::ADDR_W-1:0] sigAddr,
    input  logic [memArbPkg::BLK_W-1:0] dataBlk2Mem,
    input  logic [memArbPkg::BLK_W-1:0] accelBlk2Mem,
    input  logic                        lastBlk,
    input  logic                        txDone,
    input  logic                        rdValid,
    output logic [memArbPkg::OP_W-1:0]  op,
    output logic [memArbPkg::ADDR_W-1:0] ioAddr,
    output logic [memArbPkg::BLK_W-1:0] busOut,
    output logic                        rdStrobe,
    output logic                        wrDone,
    output logic                        blkAdvance,
    output logic                        xferDone
);
    import memArbPkg::*;

    logic [ENG_ST_W-1:0] state;
    logic [ENG_ST_W-1:0] nextState;
    logic issuing;    // op on the bus this cycle
    logic isAccel;
    logic isWrite;
    logic finalBlk;   // this completion ends the transfer
    logic [ADDR_W-1:0] instrLine;
    logic [ADDR_W-1:0] dataLine;

    // cache addresses go out line aligned
    assign instrLine = {instrAddr[ADDR_W-1:LINE_SHIFT], {LINE_SHIFT{1'b0}}};
    assign dataLine = {dataAddr[ADDR_W-1:LINE_SHIFT], {LINE_SHIFT{1'b0}}};

    assign isAccel = (grant == GNT_ACCEL_RD) || (grant == GNT_ACCEL_WR);
    assign isWrite = (grant == GNT_DATA_WR) || (grant == GNT_ACCEL_WR);
    assign finalBlk = !isAccel || lastBlk;  // a cache transfer is one block

    // idle with a fresh grant issues at once without a dead cycle
    assign issuing = (state == ENG_ISSUE) || (state == ENG_IDLE && grant != GNT_NONE);

    // bus drive held while issuing
    always_comb begin
        op = OP_IDLE;
        ioAddr = '0;
        busOut = '0;
        if (issuing) begin
            op = isWrite ? OP_WRITE : OP_READ;
            case (grant)
                GNT_INSTR: ioAddr = instrLine;
                GNT_DATA_RD, GNT_DATA_WR: ioAddr = dataLine;
                default: ioAddr = sigAddr;  // accel block
            endcase
            if (grant == GNT_DATA_WR) begin
                busOut = dataBlk2Mem;
            end else if (grant == GNT_ACCEL_WR) begin
                busOut = accelBlk2Mem;  // buffer updates between blocks
            end
        end
    end

    // next state and event strobes
    always_comb begin
        nextState = state;
        rdStrobe = 1'b0;
        wrDone = 1'b0;
        blkAdvance = 1'b0;
        xferDone = 1'b0;
        case (state)
            ENG_IDLE, ENG_ISSUE: begin
                if (issuing) begin
                    if (txDone) begin
                        nextState = isWrite ? ENG_WR_DONE : ENG_RD_WAIT;
                    end else begin
                        nextState = ENG_ISSUE;  // memory still busy
                    end
                end
            end
            ENG_RD_WAIT: begin
                if (rdValid) begin
                    rdStrobe = 1'b1;        // busIn valid now
                    blkAdvance = isAccel;
                    xferDone = finalBlk;
                    nextState = finalBlk ? ENG_IDLE : ENG_ISSUE;
                end
            end
            ENG_WR_DONE: begin
                wrDone = 1'b1;              // one cycle after txDone
                blkAdvance = isAccel;
                xferDone = finalBlk;
                nextState = finalBlk ? ENG_IDLE : ENG_ISSUE;
            end
            default: nextState = ENG_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENG_IDLE;
        end else begin
            state <= nextState;
        end
    end

    // memory controller needs op and address steady until txDone
    opHeld: assert property (@(posedge clk) disable iff (rst)
        issuing && !txDone |=> issuing && $stable(op) && $stable(ioAddr))
        else $error("op or ioAddr moved before txDone");

    // no bus activity without a grant from the decoder
    opIdleNoGrant: assert property (@(posedge clk) disable iff (rst)
        grant == GNT_NONE |-> op == OP_IDLE)
        else $error("op driven with no grant");

endmodule
